//--- Makefile
# Verilator build and run for the bus fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All tests passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Output is shown and searched for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_soc_bus.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the bus fabric: clock, reset, LFSR stimulus,
// shadow model of RAM, SRAM and LEDs, checks and watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_soc_bus;
	import soc_pkg::*;

	localparam int RAM_OPS       = 40;
	localparam int SRAM_OPS      = 30;
	localparam int LED_OPS       = 8;
	localparam int NONE_OPS      = 12;
	localparam int MIX_OPS       = 300;
	localparam int TOTAL_OPS     = 2 * (RAM_OPS + SRAM_OPS + LED_OPS) + NONE_OPS + 4 + MIX_OPS;
	localparam int CYCLES_PER_OP = 20;

	logic                 i_clock;
	logic                 i_reset;
	logic                 i_request;
	bus_req_t             i_req;
	logic                 o_ready;
	logic [31:0]          o_rdata;
	logic                 o_error;
	logic [LED_WIDTH-1:0] o_leds;

	// Shadow state
	logic [31:0]          ram_model [RAM_WORDS];
	logic                 ram_written [RAM_WORDS];
	logic [31:0]          sram_model [SRAM_WORDS];
	logic                 sram_written [SRAM_WORDS];
	logic [LED_WIDTH-1:0] led_model;
	logic [31:0]          ram_addrs [$];
	logic [31:0]          sram_addrs [$];

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          test_start_errors;
	int          tests_run;
	int          tests_failed;

	soc_bus_top u_soc_bus_top (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_req(i_req),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_error(o_error),
		.o_leds(o_leds)
	);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < n; k++) begin
			value = {value[30:0], lfsr[0]};
			if (lfsr[0])
				lfsr = (lfsr >> 1) ^ 32'h8020_0003;
			else
				lfsr = lfsr >> 1;
		end
		return value;
	endfunction

	function automatic logic [31:0] pick_address(input region_t kind);
		logic [31:0] offs;
		logic [31:0] low;
		logic [1:0]  edge_sel;
		offs = rand_bits(kind == REGION_RAM ? 8 : (kind == REGION_SRAM ? 9 : 2)) << 2;
		// Byte bits within the word are ignored by the fabric
		low = rand_bits(2);
		case (kind)
			REGION_RAM:  return RAM_BASE + offs + low;
			REGION_SRAM: return SRAM_BASE + offs + low;
			REGION_LED:  return LED_BASE + offs + low;
			default: begin
				edge_sel = 2'(rand_bits(2));
				// Far away or just past the end of each window
				case (edge_sel)
					2'd0:    return 32'h3000_0000 | rand_bits(28);
					2'd1:    return RAM_BASE + 32'(RAM_WORDS * 4) + offs;
					2'd2:    return SRAM_BASE + 32'(SRAM_WORDS * 4) + offs;
					default: return LED_BASE + 32'(LED_SPAN) + offs;
				endcase
			end
		endcase
	endfunction

	function automatic logic [31:0] distinct_halves(input logic [31:0] data);
		if (data[31:16] == data[15:0])
			return {data[31:16] ^ 16'h5a5a, data[15:0]};
		return data;
	endfunction

	// One master access that starts and ends on a falling edge
	task automatic bus_access(input logic rw, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
		output logic cleared);
		i_request     = 1'b1;
		i_req.rw      = rw;
		i_req.address = addr;
		i_req.wdata   = wdata;
		do
			@(negedge i_clock);
		while (o_ready !== 1'b1);
		rdata = o_rdata;
		err   = o_error;
		// Request stays up through the edge that retires it
		@(negedge i_clock);
		// Strobe, data and error drop back after one cycle
		cleared   = o_ready === 1'b0 && o_rdata === '0 && o_error === 1'b0;
		i_request = 1'b0;
	endtask

	task automatic check_access(input region_t kind, input logic rw,
		input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] rdata;
		logic        err;
		logic        cleared;
		logic [31:0] exp_data;
		logic        check_data;
		int          idx;
		exp_data   = '0;
		check_data = !rw;
		idx        = 0;
		if (kind == REGION_RAM) begin
			idx        = int'((addr - RAM_BASE) >> 2);
			check_data = !rw && ram_written[idx];
			exp_data   = ram_model[idx];
		end else if (kind == REGION_SRAM) begin
			idx        = int'((addr - SRAM_BASE) >> 2);
			check_data = !rw && sram_written[idx];
			exp_data   = sram_model[idx];
		end else if (kind == REGION_NONE)
			check_data = 1'b1;
		bus_access(rw, addr, wdata, rdata, err, cleared);
		checks++;
		if (err !== (kind == REGION_NONE)) begin
			$display("error: o_error addr %h expected %h got %h", addr, kind == REGION_NONE, err);
			errors++;
		end
		if (check_data && rdata !== exp_data) begin
			$display("error: o_rdata addr %h expected %h got %h", addr, exp_data, rdata);
			errors++;
		end
		if (!cleared) begin
			$display("o_ready, o_rdata or o_error still set after the ready cycle, addr %h",
				addr);
			errors++;
		end
		if (rw) begin
			if (kind == REGION_RAM) begin
				ram_model[idx]   = wdata;
				ram_written[idx] = 1'b1;
			end else if (kind == REGION_SRAM) begin
				sram_model[idx]   = wdata;
				sram_written[idx] = 1'b1;
			end else if (kind == REGION_LED)
				led_model = wdata[LED_WIDTH-1:0];
		end
		if (o_leds !== led_model) begin
			$display("error: o_leds addr %h expected %h got %h", addr, led_model, o_leds);
			errors++;
		end
	endtask

	task automatic begin_test();
		test_start_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start_errors)
			$display("test %0d %s: ok", tests_run, name);
		else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
		end
	endtask

	initial begin
		logic [31:0] addr;
		logic [31:0] data;
		region_t     kind;
		logic        rw;
		lfsr         = 32'd71;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		led_model    = '0;
		i_reset      = 1'b1;
		i_request    = 1'b0;
		i_req        = '0;
		for (int k = 0; k < RAM_WORDS; k++)
			ram_written[k] = 1'b0;
		for (int k = 0; k < SRAM_WORDS; k++)
			sram_written[k] = 1'b0;
		repeat (5) @(negedge i_clock);
		i_reset = 1'b0;
		@(negedge i_clock);

		begin_test();
		checks++;
		if (o_ready !== 1'b0 || o_error !== 1'b0) begin
			$display("error: o_ready/o_error expected %h got %h", 2'b00, {o_ready, o_error});
			errors++;
		end
		if (o_leds !== '0) begin
			$display("error: o_leds expected %h got %h", 10'h000, o_leds);
			errors++;
		end
		end_test("reset state");

		begin_test();
		for (int k = 0; k < RAM_OPS; k++) begin
			addr = pick_address(REGION_RAM);
			ram_addrs.push_back(addr);
			check_access(REGION_RAM, 1'b1, addr, rand_bits(32));
		end
		foreach (ram_addrs[k])
			check_access(REGION_RAM, 1'b0, ram_addrs[k], '0);
		end_test("ram write/read");

		begin_test();
		for (int k = 0; k < SRAM_OPS; k++) begin
			addr = pick_address(REGION_SRAM);
			sram_addrs.push_back(addr);
			check_access(REGION_SRAM, 1'b1, addr, distinct_halves(rand_bits(32)));
		end
		foreach (sram_addrs[k])
			check_access(REGION_SRAM, 1'b0, sram_addrs[k], '0);
		end_test("sram write/read");

		begin_test();
		for (int k = 0; k < LED_OPS; k++) begin
			check_access(REGION_LED, 1'b1, pick_address(REGION_LED), rand_bits(32));
			check_access(REGION_LED, 1'b0, pick_address(REGION_LED), '0);
		end
		end_test("led register");

		begin_test();
		// Word zero is where a stray unmapped access would land
		check_access(REGION_RAM, 1'b1, RAM_BASE, rand_bits(32));
		check_access(REGION_SRAM, 1'b1, SRAM_BASE, distinct_halves(rand_bits(32)));
		for (int k = 0; k < NONE_OPS; k++) begin
			rw   = 1'(rand_bits(1));
			addr = pick_address(REGION_NONE);
			data = rand_bits(32);
			check_access(REGION_NONE, rw, addr, data);
		end
		check_access(REGION_RAM, 1'b0, RAM_BASE, '0);
		check_access(REGION_SRAM, 1'b0, SRAM_BASE, '0);
		end_test("unmapped access");

		begin_test();
		for (int k = 0; k < MIX_OPS; k++) begin
			kind = region_t'(2'(rand_bits(2)));
			rw   = 1'(rand_bits(1));
			addr = pick_address(kind);
			data = rand_bits(32);
			check_access(kind, rw, addr, data);
		end
		end_test("random mix");

		$display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// Watchdog sized from the number of accesses
	initial begin
		repeat (TOTAL_OPS * CYCLES_PER_OP + 10) @(posedge i_clock);
		$display("timeout: the fabric did not return a ready strobe in time");
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- verilog/bus_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus decode stage: accepts one master request at a time and maps
// its address to a region and a word offset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_decode (
	input  logic              i_clock,
	input  logic              i_reset,
	input  logic              i_request,
	input  soc_pkg::bus_req_t i_req,
	input  logic              i_done,
	output logic              o_dec_valid,
	output soc_pkg::dec_req_t o_dec_req
);
	import soc_pkg::*;

	logic        busy;
	logic        accept;
	region_t     region;
	logic [31:0] base;
	logic [15:0] word_offset;

	assign accept = i_request && !busy;

	// Window compare, unmapped addresses keep a zero offset
	always_comb begin
		region = REGION_NONE;
		base   = i_req.address;
		if (i_req.address >= RAM_BASE && i_req.address < RAM_LIMIT) begin
			region = REGION_RAM;
			base   = RAM_BASE;
		end else if (i_req.address >= SRAM_BASE && i_req.address < SRAM_LIMIT) begin
			region = REGION_SRAM;
			base   = SRAM_BASE;
		end else if (i_req.address >= LED_BASE && i_req.address < LED_LIMIT) begin
			region = REGION_LED;
			base   = LED_BASE;
		end
		// Low two bits dropped
		word_offset = 16'((i_req.address - base) >> 2);
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy        <= 1'b0;
			o_dec_valid <= 1'b0;
		end else begin
			o_dec_valid <= accept;
			if (accept)
				busy <= 1'b1;
			else if (i_done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_dec_req.region <= region;
			o_dec_req.offset <= word_offset;
			o_dec_req.rw     <= i_req.rw;
			o_dec_req.wdata  <= i_req.wdata;
		end
	end

	// Master holds its request until the ready strobe
	a_req_held: assert property (@(posedge i_clock) disable iff (i_reset)
		busy |-> i_request && $stable(i_req))
		else $error("request changed while access in flight");

endmodule

//--- verilog/bus_execute.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus execute stage: enables the addressed device, holds the LED
// register and signals completion with the device response
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_execute (
	input  logic                          i_clock,
	input  logic                          i_reset,
	input  logic                          i_dec_valid,
	input  soc_pkg::dec_req_t             i_dec_req,
	output logic                          o_ram_enable,
	output logic                          o_ram_rw,
	output logic [15:0]                   o_ram_address,
	output logic [31:0]                   o_ram_wdata,
	input  logic [31:0]                   i_ram_rdata,
	output logic                          o_mem_enable,
	output logic                          o_mem_rw,
	output logic [15:0]                   o_mem_address,
	output logic [31:0]                   o_mem_wdata,
	input  logic [31:0]                   i_mem_rdata,
	input  logic                          i_mem_ready,
	output logic [soc_pkg::LED_WIDTH-1:0] o_leds,
	output logic                          o_done,
	output soc_pkg::dev_rsp_t             o_rsp
);
	import soc_pkg::*;

	logic ram_pending;
	logic mem_pending;
	logic pending_rw;
	logic immediate;

	// Device strobes come straight from the decode strobe
	assign o_ram_enable  = i_dec_valid && i_dec_req.region == REGION_RAM;
	assign o_ram_rw      = i_dec_req.rw;
	assign o_ram_address = i_dec_req.offset;
	assign o_ram_wdata   = i_dec_req.wdata;

	assign o_mem_enable  = i_dec_valid && i_dec_req.region == REGION_SRAM;
	assign o_mem_rw      = i_dec_req.rw;
	assign o_mem_address = i_dec_req.offset;
	assign o_mem_wdata   = i_dec_req.wdata;

	// LED and unmapped accesses finish in the decode cycle
	assign immediate = i_dec_valid &&
		(i_dec_req.region == REGION_LED || i_dec_req.region == REGION_NONE);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ram_pending <= 1'b0;
			mem_pending <= 1'b0;
			o_leds      <= '0;
		end else begin
			// RAM answers one cycle after its enable
			ram_pending <= o_ram_enable;
			if (o_mem_enable)
				mem_pending <= 1'b1;
			else if (i_mem_ready)
				mem_pending <= 1'b0;
			if (i_dec_valid && i_dec_req.region == REGION_LED && i_dec_req.rw)
				o_leds <= i_dec_req.wdata[LED_WIDTH-1:0];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_dec_valid)
			pending_rw <= i_dec_req.rw;
	end

	assign o_done = immediate || ram_pending || (mem_pending && i_mem_ready);

	// Writes, LED reads and unmapped accesses return zero
	always_comb begin
		o_rsp = '0;
		if (ram_pending && !pending_rw)
			o_rsp.rdata = i_ram_rdata;
		else if (mem_pending && !pending_rw)
			o_rsp.rdata = i_mem_rdata;
		o_rsp.error = immediate && i_dec_req.region == REGION_NONE;
	end

	// No second device starts while one is still outstanding
	a_one_device: assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0({o_ram_enable, o_mem_enable, immediate, ram_pending, mem_pending}))
		else $error("more than one device active");

endmodule

//--- verilog/bus_result.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus result stage: registers a completion into the ready strobe,
// read data and error seen by the master
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_result (
	input  logic              i_clock,
	input  logic              i_reset,
	input  logic              i_done,
	input  soc_pkg::dev_rsp_t i_rsp,
	output logic              o_ready,
	output logic [31:0]       o_rdata,
	output logic              o_error
);

	// Data and error are zero outside the ready cycle
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_rdata <= '0;
			o_error <= 1'b0;
		end else begin
			o_ready <= i_done;
			o_error <= i_done && i_rsp.error;
			if (i_done)
				o_rdata <= i_rsp.rdata;
			else
				o_rdata <= '0;
		end
	end

endmodule

//--- verilog/mem_16_to_32.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32-to-16 bridge: one word access becomes two halfword accesses,
// low half first, with the read halves joined back together
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mem_16_to_32 (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_enable,
	input  logic        i_rw,
	input  logic [15:0] i_address,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic        o_ready,
	output logic        o_ram_enable,
	output logic        o_ram_rw,
	output logic [16:0] o_ram_address,
	output logic [15:0] o_ram_wdata,
	input  logic [15:0] i_ram_rdata,
	input  logic        i_ram_ready
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOW,
		S_HIGH
	} state_t;

	state_t      state;
	logic        rw_q;
	logic [15:0] address_q;
	logic [31:0] wdata_q;
	logic [15:0] rdata_low;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state        <= S_IDLE;
			o_ram_enable <= 1'b0;
			o_ready      <= 1'b0;
		end else begin
			o_ram_enable <= 1'b0;
			o_ready      <= 1'b0;
			case (state)
				S_IDLE: if (i_enable) begin
					state        <= S_LOW;
					o_ram_enable <= 1'b1;
				end
				// Low half done, start the high half
				S_LOW: if (i_ram_ready) begin
					state        <= S_HIGH;
					o_ram_enable <= 1'b1;
				end
				S_HIGH: if (i_ram_ready) begin
					state   <= S_IDLE;
					o_ready <= 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == S_IDLE && i_enable) begin
			rw_q      <= i_rw;
			address_q <= i_address;
			wdata_q   <= i_wdata;
		end
		if (state == S_LOW && i_ram_ready)
			rdata_low <= i_ram_rdata;
		if (state == S_HIGH && i_ram_ready)
			o_rdata <= {i_ram_rdata, rdata_low};
	end

	// Halfword address is 2*word, plus one for the high half
	assign o_ram_rw      = rw_q;
	assign o_ram_address = {address_q, state == S_HIGH};
	assign o_ram_wdata   = (state == S_HIGH) ? wdata_q[31:16] : wdata_q[15:0];

	// SRAM answers only an issued halfword access
	a_ready_pending: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ram_ready |-> state != S_IDLE && !o_ram_enable)
		else $error("SRAM ready without a pending access");

endmodule

//--- verilog/soc_bus_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus fabric top: decode, execute and result stages with the word RAM,
// the 32-to-16 bridge and the external SRAM model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module soc_bus_top (
	input  logic                          i_clock,
	input  logic                          i_reset,
	input  logic                          i_request,
	input  soc_pkg::bus_req_t             i_req,
	output logic                          o_ready,
	output logic [31:0]                   o_rdata,
	output logic                          o_error,
	output logic [soc_pkg::LED_WIDTH-1:0] o_leds
);
	import soc_pkg::*;

	logic     dec_valid;
	dec_req_t dec_req;
	logic     exe_done;
	dev_rsp_t exe_rsp;

	// Word RAM
	logic        ram_enable;
	logic        ram_rw;
	logic [15:0] ram_address;
	logic [31:0] ram_wdata;
	logic [31:0] ram_rdata;

	// Bridge, 32-bit side
	logic        mem_enable;
	logic        mem_rw;
	logic [15:0] mem_address;
	logic [31:0] mem_wdata;
	logic [31:0] mem_rdata;
	logic        mem_ready;

	// Bridge, 16-bit SRAM side
	logic        sram_enable;
	logic        sram_rw;
	logic [16:0] sram_address;
	logic [15:0] sram_wdata;
	logic [15:0] sram_rdata;
	logic        sram_ready;

	bus_decode u_bus_decode (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_req(i_req),
		.i_done(o_ready),
		.o_dec_valid(dec_valid),
		.o_dec_req(dec_req)
	);

	bus_execute u_bus_execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_dec_valid(dec_valid),
		.i_dec_req(dec_req),
		.o_ram_enable(ram_enable),
		.o_ram_rw(ram_rw),
		.o_ram_address(ram_address),
		.o_ram_wdata(ram_wdata),
		.i_ram_rdata(ram_rdata),
		.o_mem_enable(mem_enable),
		.o_mem_rw(mem_rw),
		.o_mem_address(mem_address),
		.o_mem_wdata(mem_wdata),
		.i_mem_rdata(mem_rdata),
		.i_mem_ready(mem_ready),
		.o_leds(o_leds),
		.o_done(exe_done),
		.o_rsp(exe_rsp)
	);

	bus_result u_bus_result (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_done(exe_done),
		.i_rsp(exe_rsp),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_error(o_error)
	);

	word_ram u_word_ram (
		.i_clock(i_clock),
		.i_enable(ram_enable),
		.i_rw(ram_rw),
		.i_address(ram_address),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata)
	);

	mem_16_to_32 u_mem_16_to_32 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_enable(mem_enable),
		.i_rw(mem_rw),
		.i_address(mem_address),
		.i_wdata(mem_wdata),
		.o_rdata(mem_rdata),
		.o_ready(mem_ready),
		.o_ram_enable(sram_enable),
		.o_ram_rw(sram_rw),
		.o_ram_address(sram_address),
		.o_ram_wdata(sram_wdata),
		.i_ram_rdata(sram_rdata),
		.i_ram_ready(sram_ready)
	);

	sram16 #(
		.WAIT_CYCLES(SRAM_WAIT)
	) u_sram16 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_enable(sram_enable),
		.i_rw(sram_rw),
		.i_address(sram_address),
		.i_wdata(sram_wdata),
		.o_rdata(sram_rdata),
		.o_ready(sram_ready)
	);

endmodule

//--- verilog/soc_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus fabric package: address map, memory sizes and wait states,
// the region enum and the request/response structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package soc_pkg;

	// On-chip word RAM window
	localparam logic [31:0] RAM_BASE  = 32'h0001_0000;
	localparam int          RAM_WORDS = 256;
	localparam logic [31:0] RAM_LIMIT = RAM_BASE + 32'(RAM_WORDS * 4);

	// External 16-bit SRAM window, sized in 32-bit words
	localparam logic [31:0] SRAM_BASE  = 32'h1000_0000;
	localparam int          SRAM_WORDS = 512;
	localparam logic [31:0] SRAM_LIMIT = SRAM_BASE + 32'(SRAM_WORDS * 4);

	// LED register window
	localparam logic [31:0] LED_BASE  = 32'h5000_0000;
	localparam int          LED_SPAN  = 16;
	localparam logic [31:0] LED_LIMIT = LED_BASE + 32'(LED_SPAN);
	localparam int          LED_WIDTH = 10;

	// Wait states of each 16-bit SRAM access
	localparam int SRAM_WAIT = 2;

	// Array index widths
	localparam int RAM_ADDR_BITS  = $clog2(RAM_WORDS);
	localparam int SRAM_ADDR_BITS = $clog2(2 * SRAM_WORDS);

	typedef enum logic [1:0] {
		REGION_RAM,
		REGION_SRAM,
		REGION_LED,
		REGION_NONE
	} region_t;

	// Master request, rw high for a write
	typedef struct packed {
		logic        rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	// Request after decode, offset counts words from the window base
	typedef struct packed {
		region_t     region;
		logic [15:0] offset;
		logic        rw;
		logic [31:0] wdata;
	} dec_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        error;
	} dev_rsp_t;

endpackage

//--- verilog/sram16.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous 16-bit SRAM model with a fixed count of wait states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sram16 #(
	parameter int WAIT_CYCLES = soc_pkg::SRAM_WAIT
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_enable,
	input  logic        i_rw,
	input  logic [16:0] i_address,
	input  logic [15:0] i_wdata,
	output logic [15:0] o_rdata,
	output logic        o_ready
);
	import soc_pkg::*;

	// Needs at least one wait state
	localparam int COUNT_BITS = $clog2(WAIT_CYCLES + 1);

	logic [15:0]               mem [2 * SRAM_WORDS];
	logic                      busy;
	logic [COUNT_BITS-1:0]     count;
	logic                      rw_q;
	logic [SRAM_ADDR_BITS-1:0] address_q;
	logic [15:0]               wdata_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy    <= 1'b0;
			count   <= '0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= 1'b0;
			if (!busy && i_enable) begin
				busy  <= 1'b1;
				count <= COUNT_BITS'(WAIT_CYCLES - 1);
			end else if (busy) begin
				if (count == '0) begin
					busy    <= 1'b0;
					o_ready <= 1'b1;
				end else
					count <= count - 1'b1;
			end
		end
	end

	// Array access in the last wait cycle
	always_ff @(posedge i_clock) begin
		if (!busy && i_enable) begin
			rw_q      <= i_rw;
			address_q <= i_address[SRAM_ADDR_BITS-1:0];
			wdata_q   <= i_wdata;
		end
		if (busy && count == '0) begin
			if (rw_q)
				mem[address_q] <= wdata_q;
			else
				o_rdata <= mem[address_q];
		end
	end

endmodule

//--- verilog/word_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// On-chip 32-bit word RAM, writes on enable, reads one cycle later
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module word_ram (
	input  logic        i_clock,
	input  logic        i_enable,
	input  logic        i_rw,
	input  logic [15:0] i_address,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata
);
	import soc_pkg::*;

	logic [31:0]              mem [RAM_WORDS];
	logic [RAM_ADDR_BITS-1:0] index;

	// Decode keeps the offset inside the window
	assign index = i_address[RAM_ADDR_BITS-1:0];

	always_ff @(posedge i_clock) begin
		if (i_enable) begin
			if (i_rw)
				mem[index] <= i_wdata;
			else
				o_rdata <= mem[index];
		end
	end

endmodule

//--- vlog.f
verilog/soc_pkg.sv
verilog/bus_decode.sv
verilog/bus_execute.sv
verilog/bus_result.sv
verilog/word_ram.sv
verilog/mem_16_to_32.sv
verilog/sram16.sv
verilog/soc_bus_top.sv
dv/tb_soc_bus.sv
